/* tb.f */
rtl/sonyimx_pkg.sv
rtl/sensor_line_timing.sv
rtl/pixel_pattern_gen.sv
rtl/sync_code_inserter.sv
rtl/lane_serializer.sv
rtl/sonyimx_sensor_top.sv
sim/sonyimx_chk.sv
sim/tb_sonyimx.sv

/* Bender.yml */
package:
  name: sonyimx_sensor

sources:
  - files:
      - rtl/sonyimx_pkg.sv
      - rtl/sensor_line_timing.sv
      - rtl/pixel_pattern_gen.sv
      - rtl/sync_code_inserter.sv
      - rtl/lane_serializer.sv
      - rtl/sonyimx_sensor_top.sv
  - target: simulation
    files:
      - sim/sonyimx_chk.sv
      - sim/tb_sonyimx.sv

/* sim/tb_sonyimx.sv */
// testbench tb_sonyimx: clock, reset, random xvs/xhs stimulus, lane deserializers, line model
`timescale 1ns/100ps
`default_nettype none

module tb_sonyimx;
	import sonyimx_pkg::*;

	localparam int DW     = 10;
	localparam int CH     = 4;
	localparam int VBL    = 2;
	localparam int OBL    = 2;
	localparam int HBL    = 6;
	localparam int FRAMES = 8;
	// frames x longest frame in lines x (longest line + slack) x bits per word, doubled
	localparam int LIMIT  = FRAMES * (VBL + OBL + 4 + 2) * (HBL + 8 + 12 + 8) * DW * 2;
	// black level 64 at 10 bits, left aligned
	localparam logic [DW-1:0] BLANK_W = DW'(32'd4096 >> (16 - DW));
	localparam logic [DW-1:0] ONES    = '1;
	// preamble of three words as it shows in the bit history
	localparam logic [47:0] SYNC_PAT  = 48'(ONES) << (2 * DW);
	localparam logic [47:0] SYNC_MASK = (48'd1 << (3 * DW)) - 48'd1;

	typedef struct packed {
		line_kind_e  kind;
		logic [15:0] idx;
		logic [15:0] width;
		logic        first;
		logic        last;
		logic        in_frame;
	} exp_line_t;

	logic            clk;
	logic            i_reset;
	logic            i_xvs;
	logic            i_xhs;
	logic [15:0]     i_width;
	logic [15:0]     i_height;
	wire             o_clk;
	wire  [CH-1:0]   o_data;
	wire             o_fval;
	wire             o_lval;

	logic [31:0]     lcg;
	int              errors;
	int              lines_sent;
	int              lines_checked;
	int              words_checked;
	int              fill_cnt;
	int              fcnt;
	int              pos;
	logic            xhs_seen;
	logic            aligned;
	logic            in_line;
	logic            exp_fval;
	logic            fval_q;
	logic            lval_q;
	logic [47:0]     hist [CH];
	logic [DW-1:0]   wd [CH];
	exp_line_t       exp_q [$];
	exp_line_t       cur;

	sonyimx_sensor_top #(
		.DATA_WIDTH   (DW),
		.CHANNEL_NUM  (CH),
		.VBLANK_LINE  (VBL),
		.OB_LINE      (OBL),
		.HBLANK_WORDS (HBL)
	) UUT (
		.clk      (clk),
		.i_reset  (i_reset),
		.i_xvs    (i_xvs),
		.i_xhs    (i_xhs),
		.i_width  (i_width),
		.i_height (i_height),
		.o_clk    (o_clk),
		.o_data   (o_data),
		.o_fval   (o_fval),
		.o_lval   (o_lval)
	);

	bind sonyimx_sensor_top sonyimx_chk #(.DATA_WIDTH(DATA_WIDTH)) u_chk (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_word_tick (word_tick),
		.i_fval      (o_fval),
		.i_lval      (o_lval)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// random source and reference values
	// ----------------------------------------------------------------------
	function automatic int next_random(input int range);
		lcg = lcg * 32'd1103515245 + 32'd12345;
		return int'(lcg[30:16]) % range;
	endfunction

	// ramp of line*3 + pixel + lane, kept 4 codes clear of both rails
	function automatic logic [DW-1:0] model_pixel(input int line, input int pix, input int lane);
		int v;
		v = (line * 3 + pix + lane) % (1 << DW);
		if (v < 4)
			v = 4;
		if (v > (1 << DW) - 5)
			v = (1 << DW) - 5;
		return DW'(v);
	endfunction

	function automatic logic [DW-1:0] model_status(input logic v, input logic h);
		return {1'b1, v, h, {(DW - 3){1'b0}}};
	endfunction

	task automatic report_mismatch(input string what, input int lane, input int exp,
		input int got);
		errors++;
		$display("ERROR at %0t: %s on lane %0d, slot %0d, expected %h, got %h", $time, what,
			lane, pos, exp, got);
	endtask

	// ----------------------------------------------------------------------
	// one deserialized word on every lane against the line model
	// ----------------------------------------------------------------------
	task automatic check_word();
		logic [DW-1:0] exp_w;
		logic          exp_f;
		logic          exp_l;
		logic          v;
		int            w;
		if (!in_line && wd[0] == ONES) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("ERROR at %0t: sync code on the lanes with no line started", $time);
			end else begin
				cur = exp_q.pop_front();
				in_line = 1'b1;
				pos = 0;
				if (cur.first)
					exp_fval = 1'b1;
			end
		end
		w = int'(cur.width);
		v = (cur.kind == LK_BLANK);
		exp_f = in_line ? cur.in_frame : exp_fval;
		exp_l = in_line && !v && pos >= 4 && pos < w + 4;
		for (int lane = 0; lane < CH; lane++) begin
			if (!in_line)
				exp_w = BLANK_W;
			else if (pos == 0 || pos == w + 4)
				exp_w = ONES;
			else if (pos < 3 || (pos > w + 4 && pos < w + 7))
				exp_w = '0;
			else if (pos == 3)
				exp_w = model_status(v, 1'b0);
			else if (pos == w + 7)
				exp_w = model_status(v, 1'b1);
			else if (cur.kind == LK_ACTIVE)
				exp_w = model_pixel(int'(cur.idx), pos - 4, lane);
			// ob and blank pixels both sit at the black level
			else
				exp_w = BLANK_W;
			if (wd[lane] != exp_w)
				report_mismatch("lane word", lane, exp_w, wd[lane]);
		end
		if (fval_q != exp_f)
			report_mismatch("fval", 0, exp_f, fval_q);
		if (lval_q != exp_l)
			report_mismatch("lval", 0, exp_l, lval_q);
		words_checked++;
		if (in_line) begin
			pos++;
			if (pos == w + 8) begin
				in_line = 1'b0;
				lines_checked++;
				// frame ends after the eav of its last active line
				if (cur.last)
					exp_fval = 1'b0;
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// lane deserializers, sampled mid cycle
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (!i_reset) begin
			fill_cnt++;
			for (int l = 0; l < CH; l++)
				hist[l] = {hist[l][46:0], o_data[l]};
			if (!xhs_seen) begin
				if (o_fval || o_lval) begin
					errors++;
					$display("ERROR at %0t: fval or lval high before the first frame", $time);
				end
				// idle lanes repeat the blank word once the pipeline is full
				for (int l = 0; l < CH; l++) begin
					if (fill_cnt > 4 * DW && (hist[l][0] != hist[l][DW] ||
						$countones(hist[l][DW-1:0]) != $countones(BLANK_W)))
						report_mismatch("idle bit stream", l, BLANK_W, hist[l][DW-1:0]);
				end
			end
			if (!aligned) begin
				if ((hist[0] & SYNC_MASK) == SYNC_PAT) begin
					aligned = 1'b1;
					fcnt = 0;
					fval_q = o_fval;
					lval_q = o_lval;
					if (exp_q.size() == 0) begin
						errors++;
						$display("ERROR at %0t: sync code seen before any xhs", $time);
					end else begin
						// first three words of this sav are already consumed
						cur = exp_q.pop_front();
						in_line = 1'b1;
						pos = 3;
						exp_fval = 1'b1;
					end
				end
			end else begin
				fcnt++;
				// word clock high over the first half of each word
				if (o_clk != (fcnt <= DW / 2)) begin
					errors++;
					$display("ERROR at %0t: o_clk is %b in bit %0d of the word", $time, o_clk,
						fcnt - 1);
				end
				if (fcnt == DW) begin
					fcnt = 0;
					for (int l = 0; l < CH; l++)
						wd[l] = hist[l][DW-1:0];
					check_word();
					// valids lead the serial word by one word period
					fval_q = o_fval;
					lval_q = o_lval;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	task automatic wait_words(input int n);
		repeat (n * DW) @(posedge clk);
		#1;
	endtask

	task automatic send_sync(input logic with_xvs);
		i_xhs = 1'b1;
		i_xvs = with_xvs;
		xhs_seen = 1'b1;
		@(posedge clk);
		#1;
		i_xhs = 1'b0;
		i_xvs = 1'b0;
	endtask

	// line kind and index from its number after xvs
	task automatic push_line(input int ln, input int h);
		exp_line_t e;
		e = '0;
		e.width = i_width;
		e.first = (ln == 0);
		e.in_frame = (ln < VBL + OBL + h);
		e.last = (ln == VBL + OBL + h - 1);
		if (ln < VBL)
			e.kind = LK_BLANK;
		else if (ln < VBL + OBL)
			e.kind = LK_OB;
		else if (ln < VBL + OBL + h) begin
			e.kind = LK_ACTIVE;
			e.idx = 16'(ln - VBL - OBL);
		end else
			e.kind = LK_BLANK;
		exp_q.push_back(e);
		lines_sent++;
	endtask

	initial begin : stimulus
		int   h;
		int   nlines;
		int   len;
		int   s;
		int   carry;
		logic early_prev;
		i_reset = 1'b1;
		i_xvs = 1'b0;
		i_xhs = 1'b0;
		i_width = 16'd4;
		i_height = 16'd1;
		lcg = 32'h2ba7;
		errors = 0;
		lines_sent = 0;
		lines_checked = 0;
		words_checked = 0;
		fill_cnt = 0;
		fcnt = 0;
		pos = 0;
		xhs_seen = 1'b0;
		aligned = 1'b0;
		in_line = 1'b0;
		exp_fval = 1'b0;
		fval_q = 1'b0;
		lval_q = 1'b0;
		cur = '0;
		for (int l = 0; l < CH; l++)
			hist[l] = '0;
		repeat (5) @(posedge clk);
		#1;
		i_reset = 1'b0;
		wait_words(8);
		carry = 0;
		early_prev = 1'b0;
		for (int f = 0; f < FRAMES; f++) begin
			h = 1 + next_random(4);
			i_width = 16'(4 + next_random(9));
			i_height = 16'(h);
			len = HBL + 8 + int'(i_width);
			// one or two trailing blank lines per frame
			nlines = VBL + OBL + h + 1 + next_random(2);
			for (int ln = 0; ln < nlines; ln++) begin
				push_line(ln, h);
				send_sync(ln == 0);
				if (!early_prev && ln + 1 < nlines && next_random(4) == 0) begin
					// next xhs lands mid line and is held until eav
					s = 2 + next_random(len - 4);
					wait_words(s);
					carry = len - s;
					early_prev = 1'b1;
				end else begin
					wait_words(carry + len + next_random(9));
					carry = 0;
					early_prev = 1'b0;
				end
			end
		end
		wait (lines_checked == lines_sent);
		wait_words(4);
		$display("errors: %0d, assertion failures: %0d, lines checked: %0d, words checked: %0d",
			errors, UUT.u_chk.fail_count, lines_checked, words_checked);
		if (errors == 0 && UUT.u_chk.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// run limit in clock cycles
	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", LIMIT);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/sonyimx_chk.sv */
// module sonyimx_chk: concurrent assertions on valids, reset values and word tick spacing
`timescale 1ns/100ps
`default_nettype none

module sonyimx_chk #(
	parameter int DATA_WIDTH = 10
) (
	input wire clk,
	input wire i_reset,
	input wire i_word_tick,
	input wire i_fval,
	input wire i_lval
);

	// assertion failures so far
	int fail_count = 0;

	// ----------------------------------------------------------------------
	// valids
	// ----------------------------------------------------------------------
	// lval only inside a frame
	lval_in_frame: assert property (@(posedge clk) disable iff (i_reset) i_lval |-> i_fval)
		else begin
			fail_count++;
			$error("lval high while fval is low");
		end

	// both valids cleared by reset
	valids_reset: assert property (@(posedge clk) i_reset |=> (!i_fval && !i_lval))
		else begin
			fail_count++;
			$error("fval or lval high after reset");
		end

	// ----------------------------------------------------------------------
	// word strobe, one pulse per word period
	// ----------------------------------------------------------------------
	tick_period: assert property (@(posedge clk) disable iff (i_reset)
		i_word_tick |=> !i_word_tick [*(DATA_WIDTH - 1)] ##1 i_word_tick)
		else begin
			fail_count++;
			$error("word tick spacing differs from the word width");
		end

endmodule

`default_nettype wire

/* rtl/sonyimx_sensor_top.sv */
// module sonyimx_sensor_top: line timing, pattern generator, sync inserter and serializer wired up
`timescale 1ns/100ps
`default_nettype none

module sonyimx_sensor_top #(
	parameter int DATA_WIDTH   = 10,
	parameter int CHANNEL_NUM  = 4,
	parameter int VBLANK_LINE  = 2,
	parameter int OB_LINE      = 2,
	parameter int HBLANK_WORDS = 6
) (
	input  wire                    clk,
	input  wire                    i_reset,
	input  wire                    i_xvs,
	input  wire                    i_xhs,
	input  wire [15:0]             i_width,
	input  wire [15:0]             i_height,
	output wire                    o_clk,
	output wire [CHANNEL_NUM-1:0]  o_data,
	output wire                    o_fval,
	output wire                    o_lval
);
	import sonyimx_pkg::*;

	// pacing strobe for the whole pipeline
	wire                                   word_tick;
	wire line_ctrl_t                       timing_ctrl;
	wire line_ctrl_t                       pix_ctrl;
	wire [CHANNEL_NUM-1:0][DATA_WIDTH-1:0] pix_words;
	wire [CHANNEL_NUM-1:0][DATA_WIDTH-1:0] lane_words;

	// ----------------------------------------------------------------------
	// stage 0, slot counting from the sync pulses
	// ----------------------------------------------------------------------
	sensor_line_timing #(
		.VBLANK_LINE  (VBLANK_LINE),
		.OB_LINE      (OB_LINE),
		.HBLANK_WORDS (HBLANK_WORDS)
	) sensor_line_timing_inst (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_word_tick (word_tick),
		.i_xvs       (i_xvs),
		.i_xhs       (i_xhs),
		.i_width     (i_width),
		.i_height    (i_height),
		.o_ctrl      (timing_ctrl)
	);

	// stage 1, pixel data
	pixel_pattern_gen #(
		.DATA_WIDTH  (DATA_WIDTH),
		.CHANNEL_NUM (CHANNEL_NUM)
	) pixel_pattern_gen_inst (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_word_tick (word_tick),
		.i_ctrl      (timing_ctrl),
		.o_ctrl      (pix_ctrl),
		.o_pix       (pix_words)
	);

	// stage 2, sync codes merged in
	sync_code_inserter #(
		.DATA_WIDTH  (DATA_WIDTH),
		.CHANNEL_NUM (CHANNEL_NUM)
	) sync_code_inserter_inst (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_word_tick (word_tick),
		.i_ctrl      (pix_ctrl),
		.i_pix       (pix_words),
		.o_words     (lane_words),
		.o_fval      (o_fval),
		.o_lval      (o_lval)
	);

	// stage 3, serial lanes
	lane_serializer #(
		.DATA_WIDTH  (DATA_WIDTH),
		.CHANNEL_NUM (CHANNEL_NUM)
	) lane_serializer_inst (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_words     (lane_words),
		.o_word_tick (word_tick),
		.o_clk       (o_clk),
		.o_data      (o_data)
	);

endmodule

`default_nettype wire

/* rtl/lane_serializer.sv */
// module lane_serializer: word tick generation, msb first shift per lane, forwarded word clock
`timescale 1ns/100ps
`default_nettype none

module lane_serializer #(
	parameter int DATA_WIDTH  = 10,
	parameter int CHANNEL_NUM = 4
) (
	input  wire                                    clk,
	input  wire                                    i_reset,
	input  wire [CHANNEL_NUM-1:0][DATA_WIDTH-1:0]  i_words,
	output logic                                   o_word_tick,
	output logic                                   o_clk,
	output logic [CHANNEL_NUM-1:0]                 o_data
);

	localparam int CNT_W = $clog2(DATA_WIDTH);
	// o_clk high for the first HALF bits of each word
	localparam int HALF = DATA_WIDTH / 2;

	logic [CNT_W-1:0]                      bit_cnt;
	logic [CNT_W-1:0]                      n_bit_cnt;
	logic                                  clk_run;
	logic [CHANNEL_NUM-1:0][DATA_WIDTH-1:0] shreg;

	// ----------------------------------------------------------------------
	// bit counter and word tick
	// ----------------------------------------------------------------------
	// tick on the last bit, next word loads on that edge
	assign o_word_tick = (bit_cnt == CNT_W'(DATA_WIDTH - 1));
	assign n_bit_cnt = o_word_tick ? '0 : bit_cnt + 1'b1;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			bit_cnt <= '0;
			clk_run <= 1'b0;
			o_clk <= 1'b0;
		end else begin
			bit_cnt <= n_bit_cnt;
			// word clock gated off until the first tick
			if (o_word_tick)
				clk_run <= 1'b1;
			o_clk <= (clk_run || o_word_tick) && (n_bit_cnt < CNT_W'(HALF));
		end
	end

	// ----------------------------------------------------------------------
	// lane shifters
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset)
			shreg <= '0;
		else begin
			for (int lane = 0; lane < CHANNEL_NUM; lane++)
				shreg[lane] <= o_word_tick ? i_words[lane] : {shreg[lane][DATA_WIDTH-2:0], 1'b0};
		end
	end

	// msb of each shifter drives the pin
	always_comb begin
		for (int lane = 0; lane < CHANNEL_NUM; lane++)
			o_data[lane] = shreg[lane][DATA_WIDTH-1];
	end

endmodule

`default_nettype wire

/* rtl/sync_code_inserter.sv */
// module sync_code_inserter: per-lane word stream of blank words, sav, pixels and eav, aligned valids
`timescale 1ns/100ps
`default_nettype none

module sync_code_inserter #(
	parameter int DATA_WIDTH  = 10,
	parameter int CHANNEL_NUM = 4
) (
	input  wire                                      clk,
	input  wire                                      i_reset,
	input  wire                                      i_word_tick,
	input  wire sonyimx_pkg::line_ctrl_t             i_ctrl,
	input  wire [CHANNEL_NUM-1:0][DATA_WIDTH-1:0]    i_pix,
	output logic [CHANNEL_NUM-1:0][DATA_WIDTH-1:0]   o_words,
	output logic                                     o_fval,
	output logic                                     o_lval
);
	import sonyimx_pkg::*;

	localparam logic [DATA_WIDTH-1:0] BLANK =
		DATA_WIDTH'(BLANK_WORD >> (MAX_DATA_WIDTH - DATA_WIDTH));

	logic                  v_bit;
	logic                  pix_slot;
	logic [DATA_WIDTH-1:0] code;

	// ----------------------------------------------------------------------
	// code word for the slot, same on every lane
	// ----------------------------------------------------------------------
	always_comb begin
		// V marks blank lines
		v_bit = (i_ctrl.kind == LK_BLANK);
		// pixel slot of an ob or active line takes the lane word
		pix_slot = (i_ctrl.phase == WP_PIX) && !v_bit;
		case (i_ctrl.phase)
			// preamble all ones
			WP_SAV0, WP_EAV0:
				code = '1;
			WP_SAV1, WP_SAV2, WP_EAV1, WP_EAV2:
				code = '0;
			// status word, H low for sav
			WP_SAV3:
				code = DATA_WIDTH'(status_word(DATA_WIDTH, v_bit, 1'b0));
			WP_EAV3:
				code = DATA_WIDTH'(status_word(DATA_WIDTH, v_bit, 1'b1));
			// idle, and the pixel slots of blank lines
			default:
				code = BLANK;
		endcase
	end

	// ----------------------------------------------------------------------
	// output words, blank after reset so the lanes idle cleanly
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int lane = 0; lane < CHANNEL_NUM; lane++)
				o_words[lane] <= BLANK;
		end else if (i_word_tick) begin
			for (int lane = 0; lane < CHANNEL_NUM; lane++)
				o_words[lane] <= pix_slot ? i_pix[lane] : code;
		end
	end

	// valids ride along with the words
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_fval <= 1'b0;
			o_lval <= 1'b0;
		end else if (i_word_tick) begin
			o_fval <= i_ctrl.fval;
			o_lval <= i_ctrl.lval;
		end
	end

endmodule

`default_nettype wire

/* rtl/pixel_pattern_gen.sv */
// module pixel_pattern_gen: per-lane pixel words for active and ob lines, delayed line control
`timescale 1ns/100ps
`default_nettype none

module pixel_pattern_gen #(
	parameter int DATA_WIDTH  = 10,
	parameter int CHANNEL_NUM = 4
) (
	input  wire                                      clk,
	input  wire                                      i_reset,
	input  wire                                      i_word_tick,
	input  wire sonyimx_pkg::line_ctrl_t             i_ctrl,
	output sonyimx_pkg::line_ctrl_t                  o_ctrl,
	output logic [CHANNEL_NUM-1:0][DATA_WIDTH-1:0]   o_pix
);
	import sonyimx_pkg::*;

	// black level at this word width
	localparam logic [DATA_WIDTH-1:0] OB_WORD =
		DATA_WIDTH'(OB_LEVEL_FRAC >> (MAX_DATA_WIDTH - DATA_WIDTH));

	// ----------------------------------------------------------------------
	// control delayed one tick to stay with the pixels
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_reset)
			o_ctrl <= '{fval: 1'b0, lval: 1'b0, kind: LK_BLANK, phase: WP_IDLE,
				pix_idx: 16'd0, line_idx: 16'd0};
		else if (i_word_tick)
			o_ctrl <= i_ctrl;
	end

	// ----------------------------------------------------------------------
	// pixel words
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_word_tick) begin
			for (int lane = 0; lane < CHANNEL_NUM; lane++) begin
				// active pixels carry the ramp, lanes offset by one
				if (i_ctrl.phase == WP_PIX && i_ctrl.kind == LK_ACTIVE)
					o_pix[lane] <= DATA_WIDTH'(pattern_value(i_ctrl.line_idx, i_ctrl.pix_idx,
						lane, DATA_WIDTH));
				// ob lines and everything else sit at black
				else
					o_pix[lane] <= OB_WORD;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/sensor_line_timing.sv */
// module sensor_line_timing: xvs/xhs sync handling, line and word counters, line control output
`timescale 1ns/100ps
`default_nettype none

module sensor_line_timing #(
	parameter int VBLANK_LINE  = 2,
	parameter int OB_LINE      = 2,
	parameter int HBLANK_WORDS = 6
) (
	input  wire                     clk,
	input  wire                     i_reset,
	input  wire                     i_word_tick,
	input  wire                     i_xvs,
	input  wire                     i_xhs,
	input  wire [15:0]              i_width,
	input  wire [15:0]              i_height,
	output sonyimx_pkg::line_ctrl_t o_ctrl
);
	import sonyimx_pkg::*;

	// word slots within a line, 17 bits so width plus overhead fits
	localparam logic [16:0] SAV_AT = 17'(HBLANK_WORDS);
	localparam logic [16:0] PIX_AT = 17'(HBLANK_WORDS + 4);
	// line numbers after xvs
	localparam logic [16:0] OB_AT  = 17'(VBLANK_LINE);
	localparam logic [16:0] ACT_AT = 17'(VBLANK_LINE + OB_LINE);

	logic        pend_xvs;
	logic        pend_xhs;
	logic        in_line;
	logic [16:0] wcnt;
	logic [15:0] width_q;
	logic [15:0] cur_line;
	logic [15:0] next_line;
	logic        frame_on;

	logic        line_done;
	logic        take_xvs;
	logic        take_xhs;
	logic        last_active;
	logic        n_frame_on;
	logic        n_in_line;
	logic [16:0] n_wcnt;
	logic [15:0] n_width;
	logic [15:0] n_line;
	logic [15:0] n_next;
	logic [16:0] n_eav_at;
	line_ctrl_t  n_ctrl;

	// ----------------------------------------------------------------------
	// next slot
	// ----------------------------------------------------------------------
	always_comb begin
		// idle, or sitting on the last eav word
		line_done = !in_line || (wcnt == PIX_AT + {1'b0, width_q} + 17'd3);
		// syncs only act at a line boundary, mid line they wait
		take_xhs = line_done && pend_xhs;
		take_xvs = line_done && pend_xvs;
		n_frame_on = frame_on || take_xvs;
		n_in_line = in_line && !line_done;
		n_wcnt = line_done ? 17'd0 : wcnt + 17'd1;
		n_width = width_q;
		n_line = cur_line;
		n_next = take_xvs ? 16'd0 : next_line;
		if (take_xhs) begin
			n_in_line = 1'b1;
			n_width = i_width;
			n_line = n_next;
			// saturate on long runs without xvs
			if (n_next != 16'hffff)
				n_next = n_next + 16'd1;
		end
	end

	// ----------------------------------------------------------------------
	// decode of the next slot into the control word
	// ----------------------------------------------------------------------
	always_comb begin
		n_eav_at = PIX_AT + {1'b0, n_width};
		n_ctrl.phase = WP_IDLE;
		if (n_in_line) begin
			if (n_wcnt < SAV_AT)
				n_ctrl.phase = WP_IDLE;
			else if (n_wcnt < PIX_AT)
				n_ctrl.phase = word_phase_e'(4'(WP_SAV0) + 4'(n_wcnt - SAV_AT));
			else if (n_wcnt < n_eav_at)
				n_ctrl.phase = WP_PIX;
			else if (n_wcnt < n_eav_at + 17'd4)
				n_ctrl.phase = word_phase_e'(4'(WP_EAV0) + 4'(n_wcnt - n_eav_at));
		end

		// kind is fixed when the line starts
		n_ctrl.kind = o_ctrl.kind;
		if (take_xhs) begin
			if (!n_frame_on || {1'b0, n_line} < OB_AT)
				n_ctrl.kind = LK_BLANK;
			else if ({1'b0, n_line} < ACT_AT)
				n_ctrl.kind = LK_OB;
			else if ({1'b0, n_line} < ACT_AT + {1'b0, i_height})
				n_ctrl.kind = LK_ACTIVE;
			else
				n_ctrl.kind = LK_BLANK;
		end

		n_ctrl.pix_idx = (n_ctrl.phase == WP_PIX) ? 16'(n_wcnt - PIX_AT) : 16'd0;
		n_ctrl.line_idx = (n_ctrl.kind == LK_ACTIVE) ? n_line - ACT_AT[15:0] : 16'd0;
		// lval only on real pixels of ob and active lines
		n_ctrl.lval = (n_ctrl.phase == WP_PIX) && (n_ctrl.kind != LK_BLANK);

		// fval from sav0 of line 0 through eav3 of the last active line
		last_active = (o_ctrl.kind == LK_ACTIVE) &&
			({1'b0, cur_line} == ACT_AT + {1'b0, i_height} - 17'd1);
		n_ctrl.fval = o_ctrl.fval;
		if (take_xvs)
			n_ctrl.fval = 1'b0;
		if (o_ctrl.phase == WP_EAV3 && last_active)
			n_ctrl.fval = 1'b0;
		if (n_ctrl.phase == WP_SAV0 && n_frame_on && n_line == 16'd0)
			n_ctrl.fval = 1'b1;
	end

	// pending syncs, a new pulse wins over the clear
	always_ff @(posedge clk) begin
		if (i_reset) begin
			pend_xvs <= 1'b0;
			pend_xhs <= 1'b0;
		end else begin
			if (i_xvs)
				pend_xvs <= 1'b1;
			else if (i_word_tick && take_xvs)
				pend_xvs <= 1'b0;
			if (i_xhs)
				pend_xhs <= 1'b1;
			else if (i_word_tick && take_xhs)
				pend_xhs <= 1'b0;
		end
	end

	// counters and control register move one slot per word tick
	always_ff @(posedge clk) begin
		if (i_reset) begin
			in_line <= 1'b0;
			wcnt <= '0;
			width_q <= '0;
			cur_line <= '0;
			next_line <= '0;
			frame_on <= 1'b0;
			o_ctrl <= '{fval: 1'b0, lval: 1'b0, kind: LK_BLANK, phase: WP_IDLE,
				pix_idx: 16'd0, line_idx: 16'd0};
		end else if (i_word_tick) begin
			in_line <= n_in_line;
			wcnt <= n_wcnt;
			width_q <= n_width;
			cur_line <= n_line;
			next_line <= n_next;
			frame_on <= n_frame_on;
			o_ctrl <= n_ctrl;
		end
	end

endmodule

`default_nettype wire

/* rtl/sonyimx_pkg.sv */
// package: line kind and word phase enums, line control struct, sync code constants, pattern function
`default_nettype none

package sonyimx_pkg;

	// widest word the data ports are sized for
	localparam int MAX_DATA_WIDTH = 16;

	// black level 64 at 10 bits, kept left aligned in a max width word
	localparam logic [MAX_DATA_WIDTH-1:0] OB_LEVEL_FRAC = 16'd64 << (MAX_DATA_WIDTH - 10);
	// idle word sits at black level
	localparam logic [MAX_DATA_WIDTH-1:0] BLANK_WORD = OB_LEVEL_FRAC;

	typedef enum logic [1:0] {
		LK_BLANK  = 2'd0,
		LK_OB     = 2'd1,
		LK_ACTIVE = 2'd2
	} line_kind_e;

	// sav and eav codes are consecutive, so slots can be offset from the first one
	typedef enum logic [3:0] {
		WP_IDLE = 4'd0,
		WP_SAV0 = 4'd1,
		WP_SAV1 = 4'd2,
		WP_SAV2 = 4'd3,
		WP_SAV3 = 4'd4,
		WP_PIX  = 4'd5,
		WP_EAV0 = 4'd6,
		WP_EAV1 = 4'd7,
		WP_EAV2 = 4'd8,
		WP_EAV3 = 4'd9
	} word_phase_e;

	typedef struct packed {
		logic        fval;
		logic        lval;
		line_kind_e  kind;
		word_phase_e phase;
		logic [15:0] pix_idx;
		logic [15:0] line_idx;
	} line_ctrl_t;

	// ----------------------------------------------------------------------
	// fourth sync word: msb set, then V, then H, rest zero
	// ----------------------------------------------------------------------
	function automatic logic [MAX_DATA_WIDTH-1:0] status_word(input int dw, input logic v,
		input logic h);
		logic [MAX_DATA_WIDTH-1:0] w;
		w = '0;
		w[dw-1] = 1'b1;
		w[dw-2] = v;
		w[dw-3] = h;
		return w;
	endfunction

	// ----------------------------------------------------------------------
	// test pattern, clamped away from the all ones and all zero codes
	// ----------------------------------------------------------------------
	function automatic logic [MAX_DATA_WIDTH-1:0] pattern_value(input logic [15:0] line_idx,
		input logic [15:0] pix_idx, input int lane, input int dw);
		logic [31:0] sum;
		logic [31:0] full;
		full = (32'd1 << dw) - 32'd1;
		sum = 32'(line_idx) * 32'd3 + 32'(pix_idx) + 32'(lane);
		// wrap to word width
		sum = sum & full;
		if (sum < 32'd4)
			sum = 32'd4;
		else if (sum > full - 32'd4)
			sum = full - 32'd4;
		return sum[MAX_DATA_WIDTH-1:0];
	endfunction

endpackage

`default_nettype wire
